/* list.f */
+incdir+rtl
rtl/audioTxPkg.sv
rtl/audioTxCsr.sv
rtl/audioRomRead.sv
rtl/audioMixer.sv
rtl/audioFifo.sv
rtl/audioI2sTx.sv
rtl/audioTxBlock.sv
verif/spiFlashModel.sv
verif/tbAudioTx.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbAudioTx
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tbAudioTx.sv */
/*
 * Audio playback testbench
 * Flash models, I2S decoder, reference mix and per-test checks
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module tbAudioTx;

	// Samples over all playback tests, one silent frame each, slack for the underrun test
	localparam int TotalSamples = 32 + 40 + 48 + 3 + 8;
	localparam int CycleLimit   = TotalSamples * 64 * 2 * `AUDIO_BCLK_DIV + 50000;

	logic        iSCLK;
	logic        iSRST;
	logic        iBusWe;
	logic        iBusRe;
	logic [7:0]  iBusAdrs;
	logic [31:0] iBusWd;
	logic [31:0] oBusRd;
	logic [2:0]  oSfmSck;
	logic [2:0]  oSfmMosi;
	logic [2:0]  oSfmCs;
	logic [2:0]  iSfmMiso;
	logic        oI2sBclk;
	logic        oI2sLrclk;
	logic        oI2sSdata;

	logic [7:0]  flashMem [3][256];
	logic [31:0] lfsr;
	int          chStart [3];
	int          chLen [3];
	logic [15:0] gotQ [$];
	logic [15:0] expQ [$];
	logic [15:0] gotWord;
	logic [15:0] expWord;
	logic [15:0] decShift;
	logic [15:0] leftWord;
	logic [15:0] rightShift;
	logic        lrPrev;
	int          bitPos;
	logic        capture;
	logic        started;
	int          compared;
	int          checkCnt;
	int          errCnt;
	int          testErr;
	int          cycles;
	logic [31:0] rd;

	audioTxBlock dut0 (
		.iSCLK(iSCLK),         .iSRST(iSRST),
		.iBusWe(iBusWe),       .iBusRe(iBusRe),
		.iBusAdrs(iBusAdrs),   .iBusWd(iBusWd),
		.oBusRd(oBusRd),       .oSfmSck(oSfmSck),
		.oSfmMosi(oSfmMosi),   .oSfmCs(oSfmCs),
		.iSfmMiso(iSfmMiso),   .oI2sBclk(oI2sBclk),
		.oI2sLrclk(oI2sLrclk), .oI2sSdata(oI2sSdata)
	);

	spiFlashModel flash0 (.iSck(oSfmSck[0]), .iCs(oSfmCs[0]),
		.iMosi(oSfmMosi[0]), .oMiso(iSfmMiso[0]));
	spiFlashModel flash1 (.iSck(oSfmSck[1]), .iCs(oSfmCs[1]),
		.iMosi(oSfmMosi[1]), .oMiso(iSfmMiso[1]));
	spiFlashModel flash2 (.iSck(oSfmSck[2]), .iCs(oSfmCs[2]),
		.iMosi(oSfmMosi[2]), .oMiso(iSfmMiso[2]));

	// --------------------------------------------------
	// Clock and cycle limit
	// --------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #10 iSCLK = !iSCLK;
	end

	always @(posedge iSCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("Run stopped, no progress after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Galois LFSR, taps 32,22,2,1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [7:0] randByte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Expected frame k, little-endian words, done channels give zero
	function automatic logic [15:0] mixExpected(input int k);
		int sum;
		int w;
		sum = 0;
		for (int n = 0; n < 3; n++)
		begin
			if (k < chLen[n])
			begin
				w   = 2 * (chStart[n] + k);
				sum = sum + int'($signed({flashMem[n][(w + 1) % 256], flashMem[n][w % 256]}));
			end
		end
		if (sum > 32767)
		begin
			sum = 32767;
		end
		else if (sum < -32768)
		begin
			sum = -32768;
		end
		return 16'(sum);
	endfunction

	// --------------------------------------------------
	// Bus access
	// --------------------------------------------------
	task automatic busWrite(input logic [7:0] adrs, input logic [31:0] data);
		@(posedge iSCLK);
		#2;
		iBusWe   = 1'b1;
		iBusAdrs = adrs;
		iBusWd   = data;
		@(posedge iSCLK);
		#2;
		iBusWe = 1'b0;
	endtask

	task automatic busRead(input logic [7:0] adrs, output logic [31:0] data);
		@(posedge iSCLK);
		#2;
		iBusRe   = 1'b1;
		iBusAdrs = adrs;
		@(posedge iSCLK);
		#2;
		iBusRe = 1'b0;
		data   = oBusRd;
	endtask

	task automatic expectRead(input logic [7:0] adrs, input logic [31:0] mask,
		input logic [31:0] exp);
		logic [31:0] v;
		busRead(adrs, v);
		if ((v & mask) !== exp)
		begin
			$display("ERR %0t oBusRd @%h: expected %h got %h", $time, adrs, exp, v & mask);
			errCnt++;
		end
		checkCnt++;
	endtask

	// Poll the status level until the mixer is held off
	task automatic waitFifoAlert();
		logic [31:0] v;
		int          polls;
		v     = '0;
		polls = 0;
		while ((v[15:12] < `AUDIO_FIFO_ALERT) && (polls < 1000))
		begin
			busRead(8'h40, v);
			polls++;
		end
		if (v[15:12] != `AUDIO_FIFO_ALERT)
		begin
			$display("ERR %0t oBusRd fifo level: expected %0d got %0d",
				$time, `AUDIO_FIFO_ALERT, v[15:12]);
			errCnt++;
		end
		checkCnt++;
	endtask

	task automatic setChannel(input int ch, input int start, input int len, input int div);
		chStart[ch] = start;
		chLen[ch]   = len;
		busWrite(8'(ch * 16 + 4), start);
		busWrite(8'(ch * 16 + 8), start + len - 1);
		busWrite(8'(ch * 16 + 12), div);
	endtask

	// Load expected stream, enable channels, wait for every frame compared
	task automatic playAndCheck(input logic [2:0] mask, input logic checkFill);
		int frames;
		frames = 0;
		for (int n = 0; n < 3; n++)
		begin
			if (!mask[n])
			begin
				chLen[n] = 0;
			end
			frames = (chLen[n] > frames) ? chLen[n] : frames;
		end
		for (int k = 0; k < frames; k++)
		begin
			expQ.push_back(mixExpected(k));
		end
		// Silence after the last frame, nothing repeated
		expQ.push_back(16'h0000);
		gotQ.delete();
		compared = 0;
		started  = 1'b0;
		capture  = 1'b1;
		for (int n = 0; n < 3; n++)
		begin
			if (mask[n])
			begin
				busWrite(8'(n * 16), 1);
			end
		end
		if (checkFill)
		begin
			waitFifoAlert();
		end
		wait (compared == frames + 1);
		capture = 1'b0;
		expectRead(8'h40, 32'h7, {29'd0, mask});
		// Enable bit and last word address
		for (int n = 0; n < 3; n++)
		begin
			if (mask[n])
			begin
				expectRead(8'(n * 16), 32'hFFFF_FFFF,
					{16'(chStart[n] + chLen[n] - 1), 15'd0, 1'b1});
			end
		end
		for (int n = 0; n < 3; n++)
		begin
			busWrite(8'(n * 16), 0);
		end
	endtask

	// --------------------------------------------------
	// I2S decoder
	// --------------------------------------------------
	always @(posedge oI2sBclk)
	begin
		bitPos = (oI2sLrclk != lrPrev) ? 0 : bitPos + 1;
		lrPrev = oI2sLrclk;
		if ((bitPos >= 1) && (bitPos <= 16))
		begin
			if (!oI2sLrclk)
			begin
				decShift = {decShift[14:0], oI2sSdata};
				if (bitPos == 16)
				begin
					leftWord = decShift;
					// Leading silence skipped
					if (capture && (started || (decShift != 0)))
					begin
						started = 1'b1;
						gotQ.push_back(decShift);
					end
				end
			end
			else
			begin
				rightShift = {rightShift[14:0], oI2sSdata};
				// Mono, right slot repeats the left word
				if ((bitPos == 16) && (rightShift !== leftWord))
				begin
					$display("ERR %0t oI2sSdata right slot: expected %h got %h",
						$time, leftWord, rightShift);
					errCnt++;
				end
			end
		end
	end

	// Compare process
	initial
	begin
		forever
		begin
			wait ((gotQ.size() > 0) && (expQ.size() > 0));
			gotWord = gotQ.pop_front();
			expWord = expQ.pop_front();
			if (gotWord !== expWord)
			begin
				$display("ERR %0t oI2sSdata frame %0d: expected %h got %h",
					$time, compared, expWord, gotWord);
				errCnt++;
			end
			checkCnt++;
			compared++;
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		iSRST      = 1'b1;
		iBusWe     = 1'b0;
		iBusRe     = 1'b0;
		iBusAdrs   = '0;
		iBusWd     = '0;
		cycles     = 0;
		errCnt     = 0;
		checkCnt   = 0;
		capture    = 1'b0;
		lrPrev     = 1'b0;
		bitPos     = 0;
		decShift   = '0;
		leftWord   = '0;
		rightShift = '0;
		lfsr       = 32'h3344;
		for (int n = 0; n < 3; n++)
		begin
			for (int i = 0; i < 256; i++)
			begin
				flashMem[n][i] = randByte();
			end
		end
		for (int i = 0; i < 256; i++)
		begin
			flash0.mem[i] = flashMem[0][i];
			flash1.mem[i] = flashMem[1][i];
			flash2.mem[i] = flashMem[2][i];
		end
		repeat (2) @(posedge iSCLK);
		#2;
		iSRST = 1'b0;

		// Readback
		testErr = errCnt;
		expectRead(8'h40, 32'hFFFF_FFFF, 32'h0);
		busWrite(8'h14, 32'h1234);
		busWrite(8'h18, 32'h5678);
		busWrite(8'h1C, 32'h5A);
		expectRead(8'h14, 32'hFFFF_FFFF, 32'h1234);
		expectRead(8'h18, 32'hFFFF_FFFF, 32'h5678);
		expectRead(8'h1C, 32'hFFFF_FFFF, 32'h5A);
		$display("Test 1 CSR readback: %0d errors", errCnt - testErr);

		// Underrun with nothing playing
		testErr = errCnt;
		@(negedge oI2sLrclk);
		repeat (64)
		begin
			@(posedge oI2sBclk);
			if (oI2sSdata !== 1'b0)
			begin
				$display("ERR %0t oI2sSdata: expected 0 got %b", $time, oI2sSdata);
				errCnt++;
			end
		end
		checkCnt++;
		expectRead(8'h40, 32'h100, 32'h100);
		@(negedge oI2sLrclk);
		busWrite(8'h40, 32'h100);
		expectRead(8'h40, 32'h100, 32'h0);
		$display("Test 2 underrun: %0d errors", errCnt - testErr);

		// Channel 0 alone
		testErr = errCnt;
		setChannel(0, 5, 32, 3);
		playAndCheck(3'b001, 1'b0);
		$display("Test 3 single channel: %0d errors", errCnt - testErr);

		// Three overlapping ranges
		testErr = errCnt;
		setChannel(0, 0, 40, 2);
		setChannel(1, 10, 24, 1);
		setChannel(2, 20, 16, 3);
		playAndCheck(3'b111, 1'b0);
		$display("Test 4 three-channel mix: %0d errors", errCnt - testErr);

		// Fast flash fills the FIFO
		testErr = errCnt;
		setChannel(0, 40, 48, 0);
		setChannel(1, 50, 48, 0);
		playAndCheck(3'b011, 1'b1);
		$display("Test 5 back-pressure: %0d errors", errCnt - testErr);

		$display("Checks %0d, errors %0d", checkCnt, errCnt);
		if (errCnt == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verif/spiFlashModel.sv */
/*
 * Behavioral SPI flash, mode 0
 * Answers the 03 read command from a byte array, MSB first, continuous
 */
`timescale 1ns/1ps

module spiFlashModel
(
	input  logic iSck,
	input  logic iCs,
	input  logic iMosi,
	output logic oMiso
);

	// Filled by the testbench
	logic [7:0]  mem [256];
	logic [31:0] cmdShift;
	int          bitCnt;
	int          idx;
	logic [7:0]  byteAdrs;

	initial
	begin
		oMiso    = 1'b0;
		bitCnt   = 0;
		cmdShift = '0;
	end

	// New transfer on falling CS
	always @(negedge iCs)
	begin
		bitCnt = 0;
	end

	// Opcode and address in on rising SCK
	always @(posedge iSck)
	begin
		if (!iCs)
		begin
			if (bitCnt < 32)
			begin
				cmdShift = {cmdShift[30:0], iMosi};
			end
			bitCnt = bitCnt + 1;
		end
	end

	// Data out on falling SCK, ready before the next rise
	always @(negedge iSck)
	begin
		if (!iCs && (bitCnt >= 32))
		begin
			idx      = bitCnt - 32;
			byteAdrs = cmdShift[7:0] + 8'(idx / 8);
			if (cmdShift[31:24] == 8'h03)
			begin
				oMiso = mem[byteAdrs][7 - (idx % 8)];
			end
			else
			begin
				oMiso = 1'b0;
			end
		end
	end

endmodule

/* rtl/audioTxBlock.sv */
/*
 * Audio playback top level
 * Three flash readers, mixer, sample FIFO and I2S output behind a register bus
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module audioTxBlock
	import audioTxPkg::*;
(
	input  logic                     iSCLK,
	input  logic                     iSRST,
	// CPU bus
	input  logic                     iBusWe,
	input  logic                     iBusRe,
	input  logic [7:0]               iBusAdrs,
	input  logic [31:0]              iBusWd,
	output logic [31:0]              oBusRd,
	// Flash links
	output logic [`AUDIO_CH_NUM-1:0] oSfmSck,
	output logic [`AUDIO_CH_NUM-1:0] oSfmMosi,
	output logic [`AUDIO_CH_NUM-1:0] oSfmCs,
	input  logic [`AUDIO_CH_NUM-1:0] iSfmMiso,
	// I2S
	output logic                     oI2sBclk,
	output logic                     oI2sLrclk,
	output logic                     oI2sSdata
);

	chanCfgT [`AUDIO_CH_NUM-1:0]  cfg;
	chanStatT [`AUDIO_CH_NUM-1:0] stat;
	sampleT [`AUDIO_CH_NUM-1:0]   chanSample;
	chanVecT                      avail;
	chanVecT                      take;
	logic                         fifoWe;
	sampleT                       fifoWd;
	logic                         almostFull;
	fifoLvlT                      fifoLevel;
	sampleT                       fifoRd;
	logic                         notEmpty;
	logic                         pop;
	logic                         underrun;
	logic                         underrunClr;

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------
	audioTxCsr csr0 (
		.iSCLK(iSCLK),          .iSRST(iSRST),
		.iBusWe(iBusWe),        .iBusRe(iBusRe),
		.iBusAdrs(iBusAdrs),    .iBusWd(iBusWd),
		.iStat(stat),           .iUnderrun(underrun),
		.iFifoLevel(fifoLevel), .oBusRd(oBusRd),
		.oCfg(cfg),             .oUnderrunClr(underrunClr)
	);

	// --------------------------------------------------
	// One reader per flash
	// --------------------------------------------------
	for (genvar x = 0; x < `AUDIO_CH_NUM; x++)
	begin : genRom
		audioRomRead rom (
			.iSCLK(iSCLK),             .iSRST(iSRST),
			.iCfg(cfg[x]),             .iSfmMiso(iSfmMiso[x]),
			.iTake(take[x]),           .oSfmSck(oSfmSck[x]),
			.oSfmMosi(oSfmMosi[x]),    .oSfmCs(oSfmCs[x]),
			.oSample(chanSample[x]),   .oAvail(avail[x]),
			.oStat(stat[x])
		);
	end

	// Mix, buffer, serialize
	audioMixer mixer0 (
		.iSCLK(iSCLK),          .iSRST(iSRST),
		.iCfg(cfg),             .iStat(stat),
		.iSample(chanSample),   .iAvail(avail),
		.iAlmostFull(almostFull),
		.oTake(take),           .oWe(fifoWe),
		.oWd(fifoWd)
	);

	audioFifo fifo0 (
		.iSCLK(iSCLK),          .iSRST(iSRST),
		.iWe(fifoWe),           .iWd(fifoWd),
		.iPop(pop),             .oRd(fifoRd),
		.oNotEmpty(notEmpty),   .oAlmostFull(almostFull),
		.oLevel(fifoLevel)
	);

	audioI2sTx i2s0 (
		.iSCLK(iSCLK),          .iSRST(iSRST),
		.iRd(fifoRd),           .iNotEmpty(notEmpty),
		.iUnderrunClr(underrunClr),
		.oPop(pop),             .oI2sBclk(oI2sBclk),
		.oI2sLrclk(oI2sLrclk),  .oI2sSdata(oI2sSdata),
		.oUnderrun(underrun)
	);

endmodule

/* rtl/audioI2sTx.sv */
/*
 * I2S transmitter
 * 64-bit frames, same mono word in both slots, sticky underrun
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module audioI2sTx
	import audioTxPkg::*;
(
	input  logic   iSCLK,
	input  logic   iSRST,
	input  sampleT iRd,
	input  logic   iNotEmpty,
	input  logic   iUnderrunClr,
	output logic   oPop,
	output logic   oI2sBclk,
	output logic   oI2sLrclk,
	output logic   oI2sSdata,
	output logic   oUnderrun
);

	localparam int DivW = $clog2(`AUDIO_BCLK_DIV + 1);

	logic [DivW-1:0] divCnt;
	logic            tick;
	logic            fall;
	logic            frameStart;
	logic [5:0]      bitCnt;
	sampleT          sample;

	assign tick       = (divCnt == DivW'(`AUDIO_BCLK_DIV - 1));
	// Everything moves on the falling bit clock
	assign fall       = tick && oI2sBclk;
	assign frameStart = fall && (bitCnt == 6'd63);

	// Low for the left slot
	assign oI2sLrclk = bitCnt[5];

	// --------------------------------------------------
	// Bit clock and frame counter
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			divCnt   <= '0;
			oI2sBclk <= 1'b0;
			bitCnt   <= '0;
		end
		else
		begin
			divCnt <= tick ? '0 : divCnt + 1'b1;
			if (tick)
			begin
				oI2sBclk <= !oI2sBclk;
			end
			if (fall)
			begin
				bitCnt <= bitCnt + 6'd1;
			end
		end
	end

	// --------------------------------------------------
	// Serial data, pop and underrun
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oI2sSdata <= 1'b0;
			oPop      <= 1'b0;
			oUnderrun <= 1'b0;
			sample    <= '0;
		end
		else
		begin
			oPop <= frameStart && iNotEmpty;
			if (frameStart)
			begin
				// Empty FIFO plays silence
				sample <= iNotEmpty ? iRd : '0;
			end
			// Set beats clear in the same cycle
			if (frameStart && !iNotEmpty)
			begin
				oUnderrun <= 1'b1;
			end
			else if (iUnderrunClr)
			begin
				oUnderrun <= 1'b0;
			end
			// MSB one bit after the slot edge, zero pad after bit 16
			if (fall)
			begin
				oI2sSdata <= !bitCnt[4] && sample[4'd15 - bitCnt[3:0]];
			end
		end
	end

endmodule

/* rtl/audioFifo.sv */
/*
 * Show-ahead sample FIFO
 * Head word visible while not empty, almost-full at the alert level
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module audioFifo
	import audioTxPkg::*;
(
	input  logic    iSCLK,
	input  logic    iSRST,
	input  logic    iWe,
	input  sampleT  iWd,
	input  logic    iPop,
	output sampleT  oRd,
	output logic    oNotEmpty,
	output logic    oAlmostFull,
	output fifoLvlT oLevel
);

	localparam int PtrW = $clog2(`AUDIO_FIFO_DEPTH);

	sampleT          mem [`AUDIO_FIFO_DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	fifoLvlT         level;
	logic            doWr;
	logic            doRd;

	// Ignore pop when empty, write when full
	assign doRd = iPop && (level != 0);
	assign doWr = iWe && (level != `AUDIO_FIFO_DEPTH);

	assign oRd         = mem[rdPtr];
	assign oNotEmpty   = (level != 0);
	assign oAlmostFull = (level >= `AUDIO_FIFO_ALERT);
	assign oLevel      = level;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doWr)
			begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doRd)
			begin
				rdPtr <= rdPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the level alone
			case ({doWr, doRd})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (doWr)
		begin
			mem[wrPtr] <= iWd;
		end
	end

endmodule

/* rtl/audioMixer.sv */
/*
 * Lockstep saturating mixer
 * One summed frame per round of channel samples into the FIFO
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module audioMixer
	import audioTxPkg::*;
(
	input  logic                          iSCLK,
	input  logic                          iSRST,
	input  chanCfgT [`AUDIO_CH_NUM-1:0]  iCfg,
	input  chanStatT [`AUDIO_CH_NUM-1:0] iStat,
	input  sampleT [`AUDIO_CH_NUM-1:0]   iSample,
	input  chanVecT                       iAvail,
	input  logic                          iAlmostFull,
	output chanVecT                       oTake,
	output logic                          oWe,
	output sampleT                        oWd
);

	// Headroom for the full sum
	localparam int SumW = 16 + $clog2(`AUDIO_CH_NUM);

	chanVecT                want;
	logic                   ready;
	logic signed [SumW-1:0] sum;
	sampleT                 sat;

	always_comb
	begin
		// Channels that still owe a sample this frame
		for (int n = 0; n < `AUDIO_CH_NUM; n++)
		begin
			want[n] = iCfg[n].en && (!iStat[n].done || iAvail[n]);
		end
		// All owed samples present, FIFO has room, previous write gone
		ready = (|want) && ((want & ~iAvail) == '0) && !iAlmostFull && !oWe;

		sum = '0;
		for (int n = 0; n < `AUDIO_CH_NUM; n++)
		begin
			if (want[n])
			begin
				sum = sum + SumW'($signed(iSample[n]));
			end
		end

		// Clamp to 16-bit range
		if (sum > SumW'(32767))
		begin
			sat = 16'sh7FFF;
		end
		else if (sum < SumW'(-32768))
		begin
			sat = 16'sh8000;
		end
		else
		begin
			sat = sum[15:0];
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oWe   <= 1'b0;
			oTake <= '0;
		end
		else
		begin
			oWe   <= ready;
			oTake <= ready ? want : '0;
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (ready)
		begin
			oWd <= sat;
		end
	end

endmodule

/* rtl/audioRomRead.sv */
/*
 * SPI flash sample reader
 * Streams little-endian 16-bit words from start to end address, mode 0
 */
`timescale 1ns/1ps

module audioRomRead
	import audioTxPkg::*;
(
	input  logic     iSCLK,
	input  logic     iSRST,
	input  chanCfgT  iCfg,
	input  logic     iSfmMiso,
	input  logic     iTake,
	output logic     oSfmSck,
	output logic     oSfmMosi,
	output logic     oSfmCs,
	output sampleT   oSample,
	output logic     oAvail,
	output chanStatT oStat
);

	romStateE    state;
	logic        enPrev;
	logic [7:0]  divCnt;
	logic [31:0] txInit;
	logic [31:0] txShift;
	logic [4:0]  txCnt;
	logic [15:0] rxShift;
	logic [3:0]  rxCnt;
	logic        rxFull;
	logic [15:0] curAdrs;
	logic        running;
	logic        stall;
	logic        tick;
	logic        rise;
	logic        fall;
	logic        rxDone;
	logic        load;

	// Opcode then byte address, word address doubled
	assign txInit = {READ, 7'd0, iCfg.startAdrs, 1'b0};

	assign running = (state == CMD) || (state == ADDR) || (state == DATA);
	// Park SCK low while a finished word waits for the holding register
	assign stall   = rxFull && !oSfmSck;
	assign tick    = running && !stall && (divCnt == iCfg.div);
	assign rise    = tick && !oSfmSck;
	assign fall    = tick && oSfmSck;

	assign rxDone = rise && (state == DATA) && (rxCnt == 4'd15);
	// Holding register free now or emptied by the mixer this cycle
	assign load   = rxFull && (!oAvail || iTake);

	// Done only once the last word has left the shifter
	assign oStat = '{done: (state == DONE) && !rxFull, adrs: curAdrs};

	// --------------------------------------------------
	// Link control
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state    <= IDLE;
			enPrev   <= 1'b0;
			divCnt   <= '0;
			oSfmSck  <= 1'b0;
			oSfmCs   <= 1'b1;
			oSfmMosi <= 1'b0;
			txCnt    <= '0;
			rxCnt    <= '0;
			curAdrs  <= '0;
		end
		else
		begin
			enPrev <= iCfg.en;
			if (!iCfg.en)
			begin
				// Drop everything, done clears with it
				state    <= IDLE;
				divCnt   <= '0;
				oSfmSck  <= 1'b0;
				oSfmCs   <= 1'b1;
				oSfmMosi <= 1'b0;
			end
			else
			begin
				// Half period counter
				if (running && !stall)
				begin
					divCnt <= tick ? 8'd0 : divCnt + 8'd1;
				end
				if (tick)
				begin
					oSfmSck <= !oSfmSck;
				end

				case (state)
					IDLE:
					begin
						// Rising enable
						if (!enPrev)
						begin
							state    <= CMD;
							oSfmCs   <= 1'b0;
							oSfmMosi <= txInit[31];
							txCnt    <= '0;
							rxCnt    <= '0;
							divCnt   <= '0;
							curAdrs  <= iCfg.startAdrs;
						end
					end
					CMD, ADDR:
					begin
						// Next bit out on the falling edge
						if (fall)
						begin
							txCnt    <= txCnt + 5'd1;
							oSfmMosi <= txShift[30];
							if (txCnt == 5'd7)
							begin
								state <= ADDR;
							end
							if (txCnt == 5'd31)
							begin
								state    <= DATA;
								oSfmMosi <= 1'b0;
							end
						end
					end
					DATA:
					begin
						if (rise)
						begin
							rxCnt <= rxCnt + 4'd1;
						end
						// Word boundary, check for the last one
						if (fall && (rxCnt == 4'd0))
						begin
							if (curAdrs == iCfg.endAdrs)
							begin
								state  <= DONE;
								oSfmCs <= 1'b1;
							end
							else
							begin
								curAdrs <= curAdrs + 16'd1;
							end
						end
					end
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// Sample handoff
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST || !iCfg.en)
		begin
			rxFull <= 1'b0;
			oAvail <= 1'b0;
		end
		else
		begin
			if (rxDone)
			begin
				rxFull <= 1'b1;
			end
			else if (load)
			begin
				rxFull <= 1'b0;
			end
			if (load)
			begin
				oAvail <= 1'b1;
			end
			else if (iTake)
			begin
				oAvail <= 1'b0;
			end
		end
	end

	// Shifters and holding word
	always_ff @(posedge iSCLK)
	begin
		if ((state == IDLE) && iCfg.en && !enPrev)
		begin
			txShift <= txInit;
		end
		else if (fall)
		begin
			txShift <= {txShift[30:0], 1'b0};
		end
		// MSB first within a byte
		if (rise && (state == DATA))
		begin
			rxShift <= {rxShift[14:0], iSfmMiso};
		end
		// Low byte came first
		if (load)
		begin
			oSample <= {rxShift[7:0], rxShift[15:8]};
		end
	end

endmodule

/* rtl/audioTxCsr.sv */
/*
 * Audio playback register file
 * Per-channel setup, status word and the underrun clear strobe
 */
`timescale 1ns/1ps
`include "audioTx_macros.svh"

module audioTxCsr
	import audioTxPkg::*;
(
	input  logic                          iSCLK,
	input  logic                          iSRST,
	input  logic                          iBusWe,
	input  logic                          iBusRe,
	input  logic [7:0]                    iBusAdrs,
	input  logic [31:0]                   iBusWd,
	input  chanStatT [`AUDIO_CH_NUM-1:0] iStat,
	input  logic                          iUnderrun,
	input  fifoLvlT                       iFifoLevel,
	output logic [31:0]                   oBusRd,
	output chanCfgT [`AUDIO_CH_NUM-1:0]  oCfg,
	output logic                          oUnderrunClr
);

	chanCfgT [`AUDIO_CH_NUM-1:0] cfgReg;
	logic [3:0]                  selChan;
	logic [3:0]                  selOff;
	logic                        statSel;
	logic [31:0]                 rdMux;

	// Upper nibble picks the channel, lower the register
	assign selChan = iBusAdrs[7:4];
	assign selOff  = iBusAdrs[3:0];
	assign statSel = (iBusAdrs == 8'h40);

	// Write-one-to-clear, straight to the I2S side
	assign oUnderrunClr = iBusWe && statSel && iBusWd[8];

	assign oCfg = cfgReg;

	// --------------------------------------------------
	// Configuration writes
	// --------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			cfgReg <= '0;
		end
		else if (iBusWe)
		begin
			for (int n = 0; n < `AUDIO_CH_NUM; n++)
			begin
				if (selChan == 4'(n))
				begin
					case (selOff)
						4'h0: cfgReg[n].en        <= iBusWd[0];
						4'h4: cfgReg[n].startAdrs <= iBusWd[15:0];
						4'h8: cfgReg[n].endAdrs   <= iBusWd[15:0];
						4'hC: cfgReg[n].div       <= iBusWd[7:0];
						default: ;
					endcase
				end
			end
		end
	end

	// --------------------------------------------------
	// Read mux
	// --------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		if (statSel)
		begin
			// Done flags from bit 0 up
			for (int n = 0; n < `AUDIO_CH_NUM; n++)
			begin
				rdMux[n] = iStat[n].done;
			end
			rdMux[8] = iUnderrun;
			// Level clipped to the 4-bit field
			rdMux[15:12] = (iFifoLevel > 15) ? 4'hF : iFifoLevel[3:0];
		end
		else
		begin
			for (int n = 0; n < `AUDIO_CH_NUM; n++)
			begin
				if (selChan == 4'(n))
				begin
					case (selOff)
						// Live read address rides in the upper half
						4'h0: rdMux = {iStat[n].adrs, 15'd0, cfgReg[n].en};
						4'h4: rdMux = {16'd0, cfgReg[n].startAdrs};
						4'h8: rdMux = {16'd0, cfgReg[n].endAdrs};
						4'hC: rdMux = {24'd0, cfgReg[n].div};
						default: rdMux = '0;
					endcase
				end
			end
		end
	end

	// Registered read data, held between reads
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oBusRd <= '0;
		end
		else if (iBusRe)
		begin
			oBusRd <= rdMux;
		end
	end

endmodule

/* rtl/audioTxPkg.sv */
/*
 * Audio playback shared types
 * Channel configuration and status, samples, reader states and flash opcodes
 */
`include "audioTx_macros.svh"

package audioTxPkg;

	// One PCM word
	typedef logic signed [15:0] sampleT;

	// One bit per channel
	typedef logic [`AUDIO_CH_NUM-1:0] chanVecT;

	// FIFO fill level, 0 up to full depth
	localparam int FIFO_LVL_W = $clog2(`AUDIO_FIFO_DEPTH + 1);
	typedef logic [FIFO_LVL_W-1:0] fifoLvlT;

	// Per-channel setup from the CPU
	typedef struct packed {
		logic        en;
		logic [15:0] startAdrs;
		// Inclusive
		logic [15:0] endAdrs;
		// SCK half period is div+1 clocks
		logic [7:0]  div;
	} chanCfgT;

	// Per-channel progress back to the CPU
	typedef struct packed {
		logic        done;
		logic [15:0] adrs;
	} chanStatT;

	typedef enum logic [2:0] {IDLE, CMD, ADDR, DATA, DONE} romStateE;

	// Plain serial read
	typedef enum logic [7:0] {READ = 8'h03} spiCmdE;

endpackage

/* rtl/audioTx_macros.svh */
/*
 * Audio playback build constants
 * Channel count, FIFO sizing and I2S bit clock rate
 */
`ifndef AUDIO_TX_MACROS_SVH
`define AUDIO_TX_MACROS_SVH

// Flash channels, one SPI link each
`define AUDIO_CH_NUM 3

// Mixed sample FIFO in words
`define AUDIO_FIFO_DEPTH 16

// Fill level that holds the mixer off
`define AUDIO_FIFO_ALERT 12

// iSCLK cycles per bit clock half period
`define AUDIO_BCLK_DIV 2

`endif
